// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = alu_tb
FILELIST = sources.f
BIN      = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: rtl/alu_core.sv
`timescale 1ns/100ps

module alu_core
	import alu_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        cmd_strobe,
	input  alu_cmd_t    cmd,
	output logic        result_valid,
	output alu_result_t result
);

	alu_cmd_t cmd_q;     // Command under execution
	logic     cmd_valid_q;

	logic [word_width-1:0] add_sum;
	logic                  add_carry;
	logic                  cmp_above;
	logic                  cmp_below;
	logic [word_width-1:0] shift_value;
	alu_result_t           next_result;

	// Command stage
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cmd_valid_q <= 1'b0;
		end else begin
			cmd_valid_q <= cmd_strobe;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_strobe) begin
			cmd_q <= cmd;
		end
	end

	// All three units see the same registered operands
	cla_adder #(
		.width(word_width)
	) i_adder (
		.carry_in  (cmd_q.ctrl.add.carry_in),
		.a         (cmd_q.operand_a),
		.b         (cmd_q.operand_b),
		.sum       (add_sum),
		.group_prop(),
		.group_gen (),
		.carry_out (add_carry)
	);

	magnitude_comparator #(
		.width(word_width)
	) i_comparator (
		.a    (cmd_q.operand_a),
		.b    (cmd_q.operand_b),
		.above(cmp_above),
		.below(cmp_below)
	);

	barrel_shifter i_shifter (
		.data   (cmd_q.operand_a),
		.fill   (cmd_q.fill),
		.amount (cmd_q.operand_b[shamt_width-1:0]),
		.dir    (cmd_q.ctrl.shift.dir),
		.mode   (cmd_q.ctrl.shift.mode),
		.shifted(shift_value)
	);

	// Unused fields stay zero
	always_comb begin
		next_result = '0;
		case (cmd_q.op)
			op_add: begin
				next_result.value = add_sum;
				next_result.carry = add_carry;
			end
			op_cmp: begin
				next_result.above = cmp_above;
				next_result.below = cmp_below;
			end
			op_shift: next_result.value = shift_value;
			default: next_result = '0;
		endcase
	end

	// Result stage
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			result_valid <= 1'b0;
			result <= '0;
		end else begin
			result_valid <= cmd_valid_q;
			if (cmd_valid_q) begin
				result <= next_result;
			end
		end
	end

	a_no_rsvd_op: assert property (@(posedge clk) disable iff (reset)
		cmd_strobe |-> cmd.op != op_rsvd)
		else $error("strobe with reserved opcode");

	// Two register stages from strobe to valid, in both directions
	a_valid_after_strobe: assert property (@(posedge clk) disable iff (reset)
		cmd_strobe |-> ##2 result_valid)
		else $error("result_valid missing after strobe");

	a_valid_has_strobe: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> $past(cmd_strobe, 2))
		else $error("result_valid without earlier strobe");

endmodule

// File: rtl/alu_pkg.sv
package alu_pkg;

	// Datapath geometry
	localparam int word_width = 16;
	localparam int cascade_size = 4; // Lookahead fan-in, two levels at 16 bits
	localparam int shamt_width = $clog2(word_width);

	typedef enum logic [1:0] {
		op_add   = 2'd0,
		op_cmp   = 2'd1,
		op_shift = 2'd2,
		op_rsvd  = 2'd3 // Never issued
	} alu_op_e;

	// Same order as the shifter fill mux
	typedef enum logic [1:0] {
		mode_logic  = 2'd0,
		mode_arith  = 2'd1,
		mode_double = 2'd2,
		mode_cyclic = 2'd3
	} shift_mode_e;

	typedef struct packed {
		logic [1:0] spare;
		logic       carry_in;
	} add_ctrl_t;

	typedef struct packed {
		logic        dir; // 1 is left
		shift_mode_e mode;
	} shift_ctrl_t;

	// Control bits, read per opcode
	typedef union packed {
		add_ctrl_t   add;
		shift_ctrl_t shift;
	} alu_ctrl_u;

	typedef struct packed {
		alu_op_e                 op;
		alu_ctrl_u               ctrl;
		logic [word_width-1:0]   operand_a;
		logic [word_width-1:0]   operand_b; // Low bits are the shift amount
		logic [word_width-2:0]   fill;      // Double precision shift-in bits
	} alu_cmd_t;

	typedef struct packed {
		logic [word_width-1:0] value;
		logic                  carry;
		logic                  above;
		logic                  below;
	} alu_result_t;

endpackage

// File: rtl/barrel_shifter.sv
`timescale 1ns/100ps

module barrel_shifter
	import alu_pkg::*;
(
	input  logic [word_width-1:0]  data,
	input  logic [word_width-2:0]  fill,   // Shift-in bits for double mode
	input  logic [shamt_width-1:0] amount,
	input  logic                   dir,    // 1 is left
	input  shift_mode_e            mode,
	output logic [word_width-1:0]  shifted
);

	// Bits entering from the top on a right shift, from the bottom on a left shift
	logic [word_width-2:0] fill_right;
	logic [word_width-2:0] fill_left;

	// Every shift distance, selected at the end
	logic [word_width-1:0][word_width-1:0] right_ver;
	logic [word_width-1:0][word_width-1:0] left_ver;

	always_comb begin
		case (mode)
			mode_arith: begin
				fill_right = {(word_width-1){data[word_width-1]}}; // Sign copies
				fill_left = '0; // Same as logic on the left
			end
			mode_double: begin
				fill_right = fill; // Low fill bits land on top
				fill_left = fill;  // High fill bits land at the bottom
			end
			mode_cyclic: begin
				fill_right = data[word_width-2:0]; // Wraps low bits to the top
				fill_left = data[word_width-1:1];  // Wraps high bits to the bottom
			end
			default: begin
				fill_right = '0;
				fill_left = '0;
			end
		endcase
	end

	assign right_ver[0] = data;
	assign left_ver[0] = data;

	for (genvar i = 1; i < word_width; i++) begin : g_dist
		// i bits of fill on top
		assign right_ver[i] = {fill_right[i-1:0], data[word_width-1:i]};
		// Top i fill bits at the bottom
		assign left_ver[i] = {data[word_width-1-i:0], fill_left[word_width-2:word_width-1-i]};
	end

	assign shifted = dir ? left_ver[amount] : right_ver[amount];

endmodule

// File: rtl/carry_lookahead.sv
`timescale 1ns/100ps

module carry_lookahead #(
	parameter int cascade_size = 4
) (
	input  logic                    carry_in,
	input  logic [cascade_size-1:0] prop,
	input  logic [cascade_size-1:0] gen,
	output logic [cascade_size:0]   carry,
	output logic                    group_prop,
	output logic                    group_gen
);

	// Generate of each position, kept only if all higher positions propagate
	logic [cascade_size-1:0] masked_gen;

	assign carry[0] = carry_in;

	for (genvar i = 0; i < cascade_size; i++) begin : g_pos
		// Carry into the next position
		assign carry[i+1] = gen[i] | (prop[i] & carry[i]);

		if (i == cascade_size - 1) begin : g_top
			assign masked_gen[i] = gen[i]; // Nothing above the top
		end else begin : g_low
			assign masked_gen[i] = gen[i] & (&prop[cascade_size-1:i+1]);
		end
	end

	// Group terms for the next level up
	assign group_prop = &prop;
	assign group_gen = |masked_gen;

endmodule

// File: rtl/cla_adder.sv
`timescale 1ns/100ps

module cla_adder
	import alu_pkg::*;
#(
	parameter int width = word_width // Power of cascade_size
) (
	input  logic             carry_in,
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic [width-1:0] sum,
	output logic             group_prop,
	output logic             group_gen,
	output logic             carry_out
);

	localparam int child_width = width / cascade_size;

	logic [cascade_size-1:0] prop; // Per bit at a leaf, per child above
	logic [cascade_size-1:0] gen;
	logic [cascade_size:0]   carry;

	if (width > cascade_size) begin : g_tree
		// Each child adds one slice and reports its group terms
		for (genvar i = 0; i < cascade_size; i++) begin : g_child
			cla_adder #(
				.width(child_width)
			) i_child (
				.carry_in  (carry[i]),
				.a         (a[i*child_width +: child_width]),
				.b         (b[i*child_width +: child_width]),
				.sum       (sum[i*child_width +: child_width]),
				.group_prop(prop[i]),
				.group_gen (gen[i]),
				.carry_out ()
			);
		end
	end else begin : g_leaf
		// OR propagate, AND generate
		assign prop = a | b;
		assign gen = a & b;
		// prop & ~gen is the half sum
		assign sum = (prop & ~gen) ^ carry[cascade_size-1:0];
	end

	carry_lookahead #(
		.cascade_size(cascade_size)
	) i_lookahead (
		.carry_in  (carry_in),
		.prop      (prop),
		.gen       (gen),
		.carry     (carry),
		.group_prop(group_prop),
		.group_gen (group_gen)
	);

	assign carry_out = carry[cascade_size]; // Bit beyond the word

endmodule

// File: rtl/magnitude_comparator.sv
`timescale 1ns/100ps

module magnitude_comparator
	import alu_pkg::*;
#(
	parameter int width = word_width
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic             above,
	output logic             below
);

	// Tree is built over a power of two, padded with zeros on top
	localparam int levels = $clog2(width);
	localparam int padded = 1 << levels;
	localparam int nodes = 2 * padded - 1;

	logic [padded-1:0] a_pad;
	logic [padded-1:0] b_pad;

	// Heap order: node k has low child 2k+1 and high child 2k+2
	// Leaves start at padded-1, leaf j compares bit j
	logic [nodes-1:0] above_tree;
	logic [nodes-1:0] below_tree;

	always_comb begin
		a_pad = '0;
		b_pad = '0;
		a_pad[width-1:0] = a;
		b_pad[width-1:0] = b;
	end

	for (genvar j = 0; j < padded; j++) begin : g_leaf
		assign above_tree[padded-1+j] = a_pad[j] & ~b_pad[j];
		assign below_tree[padded-1+j] = ~a_pad[j] & b_pad[j];
	end

	for (genvar k = 0; k < padded - 1; k++) begin : g_node
		// High half wins unless it is equal
		assign above_tree[k] = above_tree[2*k+2] |
			(~below_tree[2*k+2] & above_tree[2*k+1]);
		assign below_tree[k] = below_tree[2*k+2] |
			(~above_tree[2*k+2] & below_tree[2*k+1]);
	end

	assign above = above_tree[0]; // Root
	assign below = below_tree[0];

	// Exclusive flags must survive every merge level
	always_comb begin
		assert final (!(above && below))
			else $error("comparator reports above and below together");
	end

endmodule

// File: sources.f
rtl/alu_pkg.sv
rtl/carry_lookahead.sv
rtl/cla_adder.sv
rtl/magnitude_comparator.sv
rtl/barrel_shifter.sv
rtl/alu_core.sv
tb/alu_clock_gen.sv
tb/alu_tb.sv

// File: tb/alu_clock_gen.sv
`timescale 1ns/100ps

module alu_clock_gen (
	output logic clk,
	output logic reset
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Held over the first three rising edges
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0; // Released on an edge, seen by the DUT on the next one
	end

endmodule

// File: tb/alu_tb.sv
`timescale 1ns/100ps

module alu_tb
	import alu_pkg::*;
();

	typedef struct packed {
		alu_cmd_t    cmd;
		alu_result_t expected;
	} row_t;

	logic        clk;
	logic        reset;
	logic        cmd_strobe;
	alu_cmd_t    cmd;
	logic        result_valid;
	alu_result_t result;

	row_t rows[$]; // Hand rows first, random rows after
	int   hand_count;
	int   seed = 32'h0a10_2439;

	alu_clock_gen i_clock_gen (
		.clk  (clk),
		.reset(reset)
	);

	alu_core i_alu_core (
		.clk         (clk),
		.reset       (reset),
		.cmd_strobe  (cmd_strobe),
		.cmd         (cmd),
		.result_valid(result_valid),
		.result      (result)
	);

	task automatic check_value(logic [31:0] actual, logic [31:0] expected, string what);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_timeout(string which);
		$display("Timeout while waiting for %s at %0t ns", which, $time);
		$display("Simulation failed");
		$fatal(1, "wait expired");
	endtask

	function automatic alu_cmd_t make_add(logic [15:0] a, logic [15:0] b, logic cin);
		alu_cmd_t c;
		c = '0;
		c.op = op_add;
		c.ctrl.add.carry_in = cin;
		c.operand_a = a;
		c.operand_b = b;
		return c;
	endfunction

	function automatic alu_cmd_t make_cmp(logic [15:0] a, logic [15:0] b);
		alu_cmd_t c;
		c = '0;
		c.op = op_cmp;
		c.operand_a = a;
		c.operand_b = b;
		return c;
	endfunction

	// b carries the amount in its low bits
	function automatic alu_cmd_t make_shift(logic dir, shift_mode_e mode, logic [15:0] a,
		logic [15:0] b, logic [14:0] fill);
		alu_cmd_t c;
		c = '0;
		c.op = op_shift;
		c.ctrl.shift.dir = dir;
		c.ctrl.shift.mode = mode;
		c.operand_a = a;
		c.operand_b = b;
		c.fill = fill;
		return c;
	endfunction

	function automatic alu_result_t make_res(logic [15:0] v, logic cy, logic ab, logic be);
		alu_result_t r;
		r.value = v;
		r.carry = cy;
		r.above = ab;
		r.below = be;
		return r;
	endfunction

	// Reference model straight from the arithmetic rules
	function automatic alu_result_t predict(alu_cmd_t c);
		alu_result_t             r;
		logic [word_width:0]     total;
		logic [2*word_width-2:0] wide; // Word joined with fill
		logic [2*word_width-1:0] twin; // Word joined with itself
		int                      n;
		r = '0;
		n = c.operand_b[shamt_width-1:0];
		case (c.op)
			op_add: begin
				total = {1'b0, c.operand_a} + {1'b0, c.operand_b} + 17'(c.ctrl.add.carry_in);
				r.value = total[word_width-1:0];
				r.carry = total[word_width]; // Bit beyond the word
			end
			op_cmp: begin
				r.above = c.operand_a > c.operand_b;
				r.below = c.operand_a < c.operand_b;
			end
			op_shift: begin
				if (c.ctrl.shift.dir) begin
					case (c.ctrl.shift.mode)
						mode_double: begin
							wide = {c.operand_a, c.fill} << n;
							r.value = wide[2*word_width-2:word_width-1];
						end
						mode_cyclic: begin
							twin = {c.operand_a, c.operand_a} << n;
							r.value = twin[2*word_width-1:word_width];
						end
						default: r.value = c.operand_a << n; // Arith same as logic
					endcase
				end else begin
					case (c.ctrl.shift.mode)
						mode_arith: r.value = $signed(c.operand_a) >>> n;
						mode_double: begin
							wide = {c.fill, c.operand_a} >> n;
							r.value = wide[word_width-1:0];
						end
						mode_cyclic: begin
							twin = {c.operand_a, c.operand_a} >> n;
							r.value = twin[word_width-1:0];
						end
						default: r.value = c.operand_a >> n;
					endcase
				end
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic add_row(alu_cmd_t c, alu_result_t e);
		row_t r;
		r.cmd = c;
		r.expected = e;
		rows.push_back(r);
	endtask

	task automatic build_table();
		alu_cmd_t c;
		int       r;
		int       sel;
		// Edge cases for the adder
		add_row(make_add(16'hffff, 16'h0001, 1'b0), make_res(16'h0000, 1'b1, 1'b0, 1'b0));
		add_row(make_add(16'h0000, 16'h0000, 1'b1), make_res(16'h0001, 1'b0, 1'b0, 1'b0));
		add_row(make_add(16'hffff, 16'hffff, 1'b1), make_res(16'hffff, 1'b1, 1'b0, 1'b0));
		add_row(make_add(16'h1234, 16'h4321, 1'b0), make_res(16'h5555, 1'b0, 1'b0, 1'b0));
		add_row(make_add(16'h8000, 16'h8000, 1'b0), make_res(16'h0000, 1'b1, 1'b0, 1'b0));
		add_row(make_cmp(16'h1234, 16'h1233), make_res(16'h0000, 1'b0, 1'b1, 1'b0));
		add_row(make_cmp(16'h0001, 16'h8000), make_res(16'h0000, 1'b0, 1'b0, 1'b1));
		add_row(make_cmp(16'h5a5a, 16'h5a5a), make_res(16'h0000, 1'b0, 1'b0, 1'b0));
		add_row(make_cmp(16'hffff, 16'h0000), make_res(16'h0000, 1'b0, 1'b1, 1'b0));
		// Right shifts by four
		add_row(make_shift(1'b0, mode_logic, 16'h9abc, 16'h0004, 15'h0000),
			make_res(16'h09ab, 0, 0, 0));
		add_row(make_shift(1'b0, mode_arith, 16'h9abc, 16'h0004, 15'h0000),
			make_res(16'hf9ab, 0, 0, 0));
		add_row(make_shift(1'b0, mode_arith, 16'h7abc, 16'h0004, 15'h0000),
			make_res(16'h07ab, 0, 0, 0));
		add_row(make_shift(1'b0, mode_double, 16'h9abc, 16'h0004, 15'h0005),
			make_res(16'h59ab, 0, 0, 0));
		add_row(make_shift(1'b0, mode_cyclic, 16'h9abc, 16'h0004, 15'h0000),
			make_res(16'hc9ab, 0, 0, 0));
		add_row(make_shift(1'b0, mode_double, 16'h8000, 16'h000f, 15'h0001),
			make_res(16'h0003, 0, 0, 0));
		add_row(make_shift(1'b0, mode_logic, 16'h9abc, 16'h0010, 15'h0000),
			make_res(16'h9abc, 0, 0, 0));
		// Left shifts
		add_row(make_shift(1'b1, mode_logic, 16'h9abc, 16'h0004, 15'h0000),
			make_res(16'habc0, 0, 0, 0));
		add_row(make_shift(1'b1, mode_arith, 16'h9abc, 16'h0004, 15'h0000),
			make_res(16'habc0, 0, 0, 0));
		add_row(make_shift(1'b1, mode_double, 16'h9abc, 16'h0004, 15'h5000),
			make_res(16'habca, 0, 0, 0));
		add_row(make_shift(1'b1, mode_cyclic, 16'h9abc, 16'h0004, 15'h0000),
			make_res(16'habc9, 0, 0, 0));
		add_row(make_shift(1'b1, mode_cyclic, 16'h8001, 16'h000f, 15'h0000),
			make_res(16'hc000, 0, 0, 0));
		add_row(make_shift(1'b1, mode_double, 16'h1234, 16'h0000, 15'h7fff),
			make_res(16'h1234, 0, 0, 0));
		hand_count = rows.size();
		// Random rows, expected from the model
		for (int i = 0; i < 24; i++) begin
			sel = $unsigned($random(seed)) % 3;
			r = $random(seed);
			case (sel)
				0: c = make_add(16'($random(seed)), 16'($random(seed)), r[0]);
				1: c = make_cmp(16'($random(seed)), 16'($random(seed)));
				default: c = make_shift(r[0], shift_mode_e'(r[2:1]), 16'($random(seed)),
					16'($random(seed)), 15'($random(seed)));
			endcase
			add_row(c, predict(c));
		end
	endtask

	// Strobes on consecutive edges
	task automatic drive_rows(int first, int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			cmd <= rows[first + i].cmd;
			cmd_strobe <= 1'b1;
		end
		@(posedge clk);
		cmd_strobe <= 1'b0;
		cmd <= '0;
	endtask

	task automatic collect_results(int first, int count);
		int waited;
		waited = 0;
		@(posedge clk); // Same edge the first strobe is driven on
		do begin
			@(negedge clk);
			waited++;
			if (waited > 20) begin
				fail_timeout("result_valid after a strobe");
			end
		end while (!result_valid);
		// Sampled one edge after driving, valid one edge after that
		check_value(waited, 3, "latency from strobe to result_valid");
		check_value(32'(result), 32'(rows[first].expected), $sformatf("row %0d result", first));
		for (int i = 1; i < count; i++) begin
			@(negedge clk);
			check_value(32'(result_valid), 1, $sformatf("row %0d result_valid", first + i));
			check_value(32'(result), 32'(rows[first + i].expected),
				$sformatf("row %0d result", first + i));
		end
		@(negedge clk);
		check_value(32'(result_valid), 0, "result_valid after the last result");
	endtask

	initial begin
		int waited;
		cmd = '0;
		cmd_strobe = 1'b0;
		build_table();
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			if (waited > 10) begin
				fail_timeout("reset release");
			end
		end while (reset);
		// Idle outputs before any strobe
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			check_value(32'(result_valid), 0, "result_valid before first strobe");
			check_value(32'(result), 0, "result before first strobe");
		end
		for (int i = 0; i < hand_count; i++) begin
			fork
				drive_rows(i, 1);
				collect_results(i, 1);
			join
		end
		// Random rows go back to back in groups of six
		for (int b = hand_count; b < rows.size(); b += 6) begin
			fork
				drive_rows(b, 6);
				collect_results(b, 6);
			join
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
